// ==== tb.f ====
src/controllerPkg.sv
src/conditionCheck.sv
src/stallLogic.sv
src/controllerState.sv
src/busOutputLogic.sv
src/datapathOutputLogic.sv
src/controller.sv
verification/controller_properties.sv
verification/controllerChecker.sv
verification/controllerTb.sv

// ==== Makefile ====
# Verilator build and run of the controller testbench.
TOP       ?= controllerTb
SEED      ?= 631089809
LOG       ?= sim.log
BUILD     ?= obj_dir
VERILATOR ?= verilator

BUILD_FLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP) \
              -GrandomSeed=$(SEED) --Mdir $(BUILD) -o sim

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f tb.f

run: build
	./$(BUILD)/sim | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/controllerTb.sv ====
`timescale 1ns/10ps

module controllerTb import controllerPkg::*; #(
    parameter logic [31:0] randomSeed = 32'h259d_aa91
);

    logic                  clk;
    logic                  rst;
    instructionWord        instruction;
    logic [FLAG_WIDTH-1:0] flags;
    logic                  exceptionPending;
    logic                  interruptPending;
    logic                  waitRequest;
    logic                  readValid;
    logic                  aluDone;
    logic                  shifterDone;
    logic                  multiplierDone;
    logic                  dividerDone;
    busControl             busCtrl;
    datapathControl        dpCtrl;
    logic                  fetchCycle;
    logic                  machineCycleDone;

    integer seed;
    integer responderSeed;
    int     maxDelay;
    int     delay;
    int     waitLimit;
    int     resetErrors;
    logic   timeoutSeen;
    logic   unitReady;
    states  lastState;
    opcodes currentOp;

    controller UUT (.*);

    controllerChecker monitor (
        .clk,
        .rst,
        .instruction,
        .flags,
        .exceptionPending,
        .interruptPending,
        .busCtrl,
        .dpCtrl,
        .machineCycleDone
    );

    bind controller controllerProperties ruleCheck (.clk, .rst, .busCtrl, .dpCtrl);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ****************************************
    // Bus and unit responder
    // ****************************************
    always @(negedge clk) begin
        if (rst) begin
            delay = 0;
            lastState = FETCH0;
        end else begin
            // A fresh random delay is drawn each time a new state is entered.
            if (UUT.state != lastState) begin
                delay = $unsigned($random(responderSeed)) % (maxDelay + 1);
            end else if (delay > 0) begin
                delay = delay - 1;
            end
            lastState = UUT.state;
        end
        waitRequest = !rst && delay > 0 && UUT.state inside {FETCH0, MEMORY};
        readValid = !rst && delay == 0 && UUT.state inside {FETCH1, MEMORY};
        unitReady = !rst && delay == 0 && UUT.state == EXECUTE;
        aluDone = unitReady && currentOp inside {ADD, SUB, AND, OR, LOAD, STORE};
        shifterDone = unitReady && currentOp == SHL;
        multiplierDone = unitReady && currentOp == MUL;
        dividerDone = unitReady && currentOp == DIV;
    end

    task automatic waitForFetch();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!machineCycleDone && cycles < waitLimit) begin
            cycles++;
            @(negedge clk);
        end
        if (!machineCycleDone) begin
            timeoutSeen = 1'b1;
            $display("Timeout: the DUT did not return to fetch within %0d cycles", waitLimit);
        end
    endtask

    task automatic runInstruction(opcodes op, conditions cond, logic [3:0] flagValue,
                                  logic exc, logic intr);
        int cycles;
        cycles = 0;
        if (!timeoutSeen) begin
            waitForFetch();
        end
        if (!timeoutSeen) begin
            currentOp = op;
            instruction = {op, cond, 8'($random(seed))};
            flags = flagValue;
            exceptionPending = exc;
            interruptPending = intr;
            while (machineCycleDone && cycles < waitLimit) begin
                cycles++;
                @(negedge clk);
            end
            if (machineCycleDone) begin
                timeoutSeen = 1'b1;
                $display("Timeout: the DUT stayed in FETCH0 for %0d cycles", waitLimit);
            end
        end
    endtask

    initial begin
        seed = randomSeed;
        responderSeed = randomSeed ^ 32'h5a5a_5a5a;
        rst = 1'b1;
        instruction = {NOP, ALWAYS, 8'h00};
        currentOp = NOP;
        flags = '0;
        exceptionPending = 1'b0;
        interruptPending = 1'b0;
        waitRequest = 1'b0;
        readValid = 1'b0;
        aluDone = 1'b0;
        shifterDone = 1'b0;
        multiplierDone = 1'b0;
        dividerDone = 1'b0;
        maxDelay = 3;
        waitLimit = 200;
        resetErrors = 0;
        timeoutSeen = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (busCtrl == '0 && dpCtrl == '0 && fetchCycle) begin
            $display("Pass reset at %0t", $time);
        end else begin
            resetErrors++;
            $display("Fail at %0t: reset left busCtrl %h dpCtrl %h fetchCycle %b",
                     $time, busCtrl, dpCtrl, fetchCycle);
        end

        for (int i = 0; i <= 6; i++) begin
            repeat (3) runInstruction(opcodes'(i), ALWAYS, 4'($random(seed)), 1'b0, 1'b0);
        end
        repeat (4) begin
            runInstruction(LOAD, ALWAYS, 4'($random(seed)), 1'b0, 1'b0);
            runInstruction(STORE, ALWAYS, 4'($random(seed)), 1'b0, 1'b0);
        end
        // Pending events during a branch must be ignored.
        for (int c = 0; c <= 9; c++) begin
            repeat (2) runInstruction(BRANCH, conditions'(c), 4'($random(seed)),
                                      1'($random(seed)), 1'($random(seed)));
        end
        repeat (2) runInstruction(NOP, ALWAYS, 4'($random(seed)), 1'b0, 1'b0);
        runInstruction(TRAP, ALWAYS, 4'h0, 1'b0, 1'b0);
        runInstruction(ADD, ALWAYS, 4'h0, 1'b1, 1'b0);
        runInstruction(MUL, ALWAYS, 4'h0, 1'b0, 1'b1);
        runInstruction(SUB, ALWAYS, 4'h0, 1'b1, 1'b1);
        runInstruction(TRAP, ALWAYS, 4'h0, 1'b0, 1'b0);

        // Long stalls on every phase that can stall.
        maxDelay = 12;
        repeat (20) begin
            runInstruction(opcodes'($unsigned($random(seed)) % 12),
                           conditions'($unsigned($random(seed)) % 10),
                           4'($random(seed)), 1'b0, 1'b0);
        end

        if (!timeoutSeen) begin
            waitForFetch();
        end
        repeat (3) @(negedge clk);

        $display("Tests: %0d passed, %0d failed, %0d assertion failures",
                 monitor.passCount, monitor.failCount + resetErrors,
                 UUT.ruleCheck.failures);
        if (timeoutSeen || monitor.failCount != 0 || resetErrors != 0 ||
            UUT.ruleCheck.failures != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

// ==== verification/controllerChecker.sv ====
`timescale 1ns/10ps

module controllerChecker import controllerPkg::*; (
    input logic                  clk,
    input logic                  rst,
    input instructionWord        instruction,
    input logic [FLAG_WIDTH-1:0] flags,
    input logic                  exceptionPending,
    input logic                  interruptPending,
    input busControl             busCtrl,
    input datapathControl        dpCtrl,
    input logic                  machineCycleDone
);

    typedef struct packed {
        logic [3:0] memReads;
        logic [3:0] memWrites;
        logic [3:0] addressFromPcs;
        logic [3:0] addressFromResults;
        logic [3:0] dataDrives;
        logic [3:0] pcIncrements;
        logic [3:0] pcVectors;
        logic [3:0] regWrites;
        logic [3:0] flagsWrites;
        logic [3:0] pcLoads;
        logic [3:0] unitStarts;
        logic [3:0] exceptionEnters;
        logic [1:0] resultSelect;
    } instructionSummary;

    int passCount = 0;
    int failCount = 0;

    instructionSummary     observed;
    instructionWord        capturedWord;
    logic [FLAG_WIDTH-1:0] capturedFlags;
    logic                  capturedException;
    logic                  capturedInterrupt;
    logic                  active;
    logic                  fetchLast;
    logic                  fetchBefore;
    logic                  readLast;
    logic                  writeLast;

    // Flags run negative, zero, carry, overflow from the top bit down.
    function automatic logic branchTaken(conditions cond, logic [3:0] f);
        case (cond)
            ALWAYS:  return 1'b1;
            EQ:      return f[2];
            NE:      return !f[2];
            CS:      return f[1];
            CC:      return !f[1];
            MI:      return f[3];
            PL:      return !f[3];
            VS:      return f[0];
            VC:      return !f[0];
            default: return 1'b0;
        endcase
    endfunction

    // ****************************************
    // Reference summary of one instruction
    // ****************************************
    function automatic instructionSummary expectedSummary(instructionWord word,
                                                          logic [3:0] f,
                                                          logic exc,
                                                          logic intr);
        instructionSummary s;
        opcodes            op;
        logic              arith;
        logic              boundary;
        s = '0;
        op = word.registerForm.opcode;
        arith = op inside {ADD, SUB, AND, OR, SHL, MUL, DIV};
        // Events are only taken where the instruction ends through writeback or a NOP.
        boundary = arith || op == LOAD || op == NOP;
        s.memReads = (op == LOAD) ? 4'd2 : 4'd1;
        s.memWrites = 4'(op == STORE);
        s.addressFromPcs = 4'd1;
        s.addressFromResults = 4'(op == LOAD || op == STORE);
        s.dataDrives = 4'(op == STORE);
        s.pcIncrements = 4'd1;
        s.unitStarts = 4'(arith || op == LOAD || op == STORE);
        s.regWrites = 4'(arith || op == LOAD);
        s.flagsWrites = 4'(op inside {ADD, SUB, AND, OR, SHL});
        s.pcLoads = 4'(op == BRANCH && branchTaken(word.branchForm.condition, f));
        s.exceptionEnters = 4'(op == TRAP || (boundary && (exc || intr)));
        s.pcVectors = s.exceptionEnters;
        case (op)
            SHL:      s.resultSelect = 2'd1;
            MUL, DIV: s.resultSelect = 2'd2;
            LOAD:     s.resultSelect = 2'd3;
            default:  s.resultSelect = 2'd0;
        endcase
        return s;
    endfunction

    task automatic compareSummary();
        instructionSummary expected;
        expected = expectedSummary(capturedWord, capturedFlags, capturedException,
                                   capturedInterrupt);
        if (observed == expected) begin
            passCount++;
            $display("Pass %s at %0t", capturedWord.registerForm.opcode.name(), $time);
        end else begin
            failCount++;
            $display("Fail at %0t: %s summary expected %h, observed %h", $time,
                     capturedWord.registerForm.opcode.name(), expected, observed);
        end
    endtask

    // Outputs trail the state by one cycle, so the window opens a cycle after FETCH0.
    always @(posedge clk) begin
        if (rst) begin
            active = 1'b0;
            fetchLast = 1'b0;
            fetchBefore = 1'b0;
            readLast = 1'b0;
            writeLast = 1'b0;
            observed = '0;
        end else begin
            if (fetchLast && !fetchBefore) begin
                if (active) begin
                    compareSummary();
                end
                active = 1'b1;
                capturedWord = instruction;
                capturedFlags = flags;
                capturedException = exceptionPending;
                capturedInterrupt = interruptPending;
                observed = '0;
            end
            if (busCtrl.memRead && !readLast) begin
                observed.memReads = observed.memReads + 4'd1;
            end
            if (busCtrl.memWrite && !writeLast) begin
                observed.memWrites = observed.memWrites + 4'd1;
            end
            if (dpCtrl.regWrite) begin
                observed.regWrites = observed.regWrites + 4'd1;
                observed.resultSelect = dpCtrl.resultSelect;
            end
            observed.addressFromPcs = observed.addressFromPcs + 4'(busCtrl.addressFromPc);
            observed.addressFromResults = observed.addressFromResults +
                                          4'(busCtrl.addressFromResult);
            observed.dataDrives = observed.dataDrives + 4'(busCtrl.dataDrive);
            observed.pcIncrements = observed.pcIncrements + 4'(dpCtrl.pcIncrement);
            observed.pcVectors = observed.pcVectors + 4'(dpCtrl.pcVector);
            observed.flagsWrites = observed.flagsWrites + 4'(dpCtrl.flagsWrite);
            observed.pcLoads = observed.pcLoads + 4'(dpCtrl.pcLoad);
            observed.unitStarts = observed.unitStarts + 4'(dpCtrl.unitStart);
            observed.exceptionEnters = observed.exceptionEnters + 4'(dpCtrl.exceptionEnter);
            readLast = busCtrl.memRead;
            writeLast = busCtrl.memWrite;
            fetchBefore = fetchLast;
            fetchLast = machineCycleDone;
        end
    end

endmodule

// ==== verification/controller_properties.sv ====
`timescale 1ns/10ps

module controllerProperties import controllerPkg::*; (
    input logic           clk,
    input logic           rst,
    input busControl      busCtrl,
    input datapathControl dpCtrl
);

    int failures = 0;

    // The bus carries one transaction direction at a time.
    exclusiveBusAccess: assert property (
        @(posedge clk) disable iff (rst) !(busCtrl.memRead && busCtrl.memWrite)
    ) else begin
        $error("memRead and memWrite are high in the same cycle");
        failures++;
    end

    // A register write never shares a cycle with exception entry.
    exclusiveWriteback: assert property (
        @(posedge clk) disable iff (rst) !(dpCtrl.regWrite && dpCtrl.exceptionEnter)
    ) else begin
        $error("regWrite and exceptionEnter are high in the same cycle");
        failures++;
    end

    resetClearsWords: assert property (
        @(posedge clk) $rose(rst) |=> (busCtrl == '0 && dpCtrl == '0)
    ) else begin
        $error("control words are not zero after reset");
        failures++;
    end

endmodule

// ==== src/controller.sv ====
`timescale 1ns/10ps

module controller import controllerPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  instructionWord        instruction,
    input  logic [FLAG_WIDTH-1:0] flags,
    input  logic                  exceptionPending,
    input  logic                  interruptPending,
    input  logic                  waitRequest,
    input  logic                  readValid,
    input  logic                  aluDone,
    input  logic                  shifterDone,
    input  logic                  multiplierDone,
    input  logic                  dividerDone,
    output busControl             busCtrl,
    output datapathControl        dpCtrl,
    output logic                  fetchCycle,
    output logic                  machineCycleDone
);

    opcodes    opcode;
    conditions condition;
    logic      conditionResult;
    logic      enable;
    states     state;

    // The opcode sits in the same place in both forms.
    assign opcode = instruction.registerForm.opcode;
    assign condition = instruction.branchForm.condition;

    assign fetchCycle = state inside {FETCH0, FETCH1, FETCH2, FETCH3};
    assign machineCycleDone = (state == FETCH0);

    conditionCheck conditionCheck (
        .condition,
        .flags,
        .conditionResult
    );

    stallLogic stallLogic (
        .state,
        .opcode,
        .waitRequest,
        .readValid,
        .aluDone,
        .shifterDone,
        .multiplierDone,
        .dividerDone,
        .enable
    );

    controllerState controllerState (
        .clk,
        .rst,
        .enable,
        .conditionResult,
        .exceptionPending,
        .interruptPending,
        .opcode,
        .state
    );

    busOutputLogic busOutputLogic (
        .clk,
        .rst,
        .enable,
        .opcode,
        .state,
        .busCtrl
    );

    datapathOutputLogic datapathOutputLogic (
        .clk,
        .rst,
        .enable,
        .conditionResult,
        .exceptionPending,
        .interruptPending,
        .opcode,
        .state,
        .dpCtrl
    );

endmodule

// ==== src/datapathOutputLogic.sv ====
`timescale 1ns/10ps

module datapathOutputLogic import controllerPkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           enable,
    input  logic           conditionResult,
    input  logic           exceptionPending,
    input  logic           interruptPending,
    input  opcodes         opcode,
    input  states          state,
    output datapathControl dpCtrl
);

    datapathControl nextCtrl;

    always_comb begin
        nextCtrl = '0;
        case (state)
            FETCH3: nextCtrl.pcIncrement = 1'b1;
            DECODE: begin
                nextCtrl.pcLoad = (opcode == BRANCH) && conditionResult;
                nextCtrl.unitStart = !(opcode inside {NOP, BRANCH, TRAP});
            end
            WRITEBACK: begin
                nextCtrl.regWrite = (opcode != STORE);
                nextCtrl.flagsWrite = opcode inside {ADD, SUB, AND, OR, SHL};
                case (opcode)
                    SHL:      nextCtrl.resultSelect = RESULT_SHIFTER;
                    MUL, DIV: nextCtrl.resultSelect = RESULT_UNIT;
                    LOAD:     nextCtrl.resultSelect = RESULT_MEMORY;
                    default:  nextCtrl.resultSelect = RESULT_ALU;
                endcase
            end
            EXCEPTION: begin
                nextCtrl.exceptionEnter = 1'b1;
                nextCtrl.pcVector = 1'b1;
            end
            default:   nextCtrl = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dpCtrl <= '0;
        end else begin
            dpCtrl <= enable ? nextCtrl : '0;
        end
    end

endmodule

// ==== src/busOutputLogic.sv ====
`timescale 1ns/10ps

module busOutputLogic import controllerPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  opcodes    opcode,
    input  states     state,
    output busControl busCtrl
);

    busControl nextCtrl;
    busControl holdCtrl;

    always_comb begin
        nextCtrl = '0;
        case (state)
            FETCH0: begin
                nextCtrl.memRead = 1'b1;
                nextCtrl.addressFromPc = 1'b1;
            end
            MEMORY: begin
                nextCtrl.addressFromResult = 1'b1;
                if (opcode == STORE) begin
                    nextCtrl.memWrite = 1'b1;
                    nextCtrl.dataDrive = 1'b1;
                end else begin
                    nextCtrl.memRead = 1'b1;
                end
            end
            default: nextCtrl = '0;
        endcase
    end

    // The read and write levels ride through a stall while everything else drops.
    always_comb begin
        holdCtrl = '0;
        holdCtrl.memRead = busCtrl.memRead;
        holdCtrl.memWrite = busCtrl.memWrite;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busCtrl <= '0;
        end else begin
            busCtrl <= enable ? nextCtrl : holdCtrl;
        end
    end

endmodule

// ==== src/controllerState.sv ====
`timescale 1ns/10ps

module controllerState import controllerPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   enable,
    input  logic   conditionResult,
    input  logic   exceptionPending,
    input  logic   interruptPending,
    input  opcodes opcode,
    output states  state
);

    states nextState;
    logic  eventPending;

    // Exceptions and interrupts share one entry sequence.
    assign eventPending = exceptionPending || interruptPending;

    // ****************************************
    // Phase sequencing
    // ****************************************
    always_comb begin
        nextState = state;
        case (state)
            FETCH0: nextState = FETCH1;
            FETCH1: nextState = FETCH2;
            FETCH2: nextState = FETCH3;
            FETCH3: nextState = DECODE;
            DECODE: begin
                case (opcode)
                    NOP:     nextState = eventPending ? EXCEPTION : FETCH0;
                    TRAP:    nextState = EXCEPTION;
                    BRANCH:  nextState = FETCH0;
                    default: nextState = EXECUTE;
                endcase
            end
            EXECUTE: begin
                if (opcode == LOAD || opcode == STORE) begin
                    nextState = MEMORY;
                end else begin
                    nextState = WRITEBACK;
                end
            end
            MEMORY:    nextState = (opcode == LOAD) ? WRITEBACK : FETCH0;
            WRITEBACK: nextState = eventPending ? EXCEPTION : FETCH0;
            EXCEPTION: nextState = FETCH0;
            default:   nextState = FETCH0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH0;
        end else if (enable) begin
            state <= nextState;
        end
    end

endmodule

// ==== src/stallLogic.sv ====
`timescale 1ns/10ps

module stallLogic import controllerPkg::*; (
    input  states  state,
    input  opcodes opcode,
    input  logic   waitRequest,
    input  logic   readValid,
    input  logic   aluDone,
    input  logic   shifterDone,
    input  logic   multiplierDone,
    input  logic   dividerDone,
    output logic   enable
);

    logic unitDone;

    // Loads and stores compute their address in the ALU.
    always_comb begin
        case (opcode)
            SHL:     unitDone = shifterDone;
            MUL:     unitDone = multiplierDone;
            DIV:     unitDone = dividerDone;
            ADD, SUB, AND, OR, LOAD, STORE: unitDone = aluDone;
            default: unitDone = 1'b1;
        endcase
    end

    always_comb begin
        case (state)
            FETCH0:  enable = ~waitRequest;
            FETCH1:  enable = readValid;
            EXECUTE: enable = unitDone;
            MEMORY:  enable = ~waitRequest && (opcode != LOAD || readValid);
            default: enable = 1'b1;
        endcase
    end

endmodule

// ==== src/conditionCheck.sv ====
`timescale 1ns/10ps

module conditionCheck import controllerPkg::*; (
    input  conditions              condition,
    input  logic [FLAG_WIDTH-1:0]  flags,
    output logic                   conditionResult
);

    always_comb begin
        case (condition)
            ALWAYS:  conditionResult = 1'b1;
            EQ:      conditionResult = flags[FLAG_ZERO];
            NE:      conditionResult = ~flags[FLAG_ZERO];
            CS:      conditionResult = flags[FLAG_CARRY];
            CC:      conditionResult = ~flags[FLAG_CARRY];
            MI:      conditionResult = flags[FLAG_NEGATIVE];
            PL:      conditionResult = ~flags[FLAG_NEGATIVE];
            VS:      conditionResult = flags[FLAG_OVERFLOW];
            VC:      conditionResult = ~flags[FLAG_OVERFLOW];
            // NEVER and the unused codes are never taken.
            default: conditionResult = 1'b0;
        endcase
    end

endmodule

// ==== src/controllerPkg.sv ====
package controllerPkg;

    localparam int WORD_WIDTH = 16;
    localparam int FLAG_WIDTH = 4;
    localparam int FIELD_WIDTH = 4;
    localparam int OFFSET_WIDTH = WORD_WIDTH - 2 * FIELD_WIDTH;

    // Flag positions, negative in the top bit.
    localparam int FLAG_NEGATIVE = 3;
    localparam int FLAG_ZERO = 2;
    localparam int FLAG_CARRY = 1;
    localparam int FLAG_OVERFLOW = 0;

    // Codes for the datapath result multiplexer.
    localparam logic [1:0] RESULT_ALU = 2'd0;
    localparam logic [1:0] RESULT_SHIFTER = 2'd1;
    localparam logic [1:0] RESULT_UNIT = 2'd2;
    localparam logic [1:0] RESULT_MEMORY = 2'd3;

    typedef enum logic [FIELD_WIDTH-1:0] {
        ADD, SUB, AND, OR, SHL, MUL, DIV, LOAD, STORE, BRANCH, NOP, TRAP
    } opcodes;

    typedef enum logic [FIELD_WIDTH-1:0] {
        ALWAYS, EQ, NE, CS, CC, MI, PL, VS, VC, NEVER
    } conditions;

    typedef enum logic [3:0] {
        FETCH0, FETCH1, FETCH2, FETCH3, DECODE, EXECUTE, MEMORY, WRITEBACK, EXCEPTION
    } states;

    typedef union packed {
        struct packed {
            opcodes                 opcode;
            logic [FIELD_WIDTH-1:0] rd;
            logic [FIELD_WIDTH-1:0] ra;
            logic [FIELD_WIDTH-1:0] rb;
        } registerForm;
        struct packed {
            opcodes                  opcode;
            conditions               condition;
            logic [OFFSET_WIDTH-1:0] offset;
        } branchForm;
    } instructionWord;

    typedef struct packed {
        logic memRead;
        logic memWrite;
        logic addressFromPc;
        logic addressFromResult;
        logic dataDrive;
    } busControl;

    typedef struct packed {
        logic       pcIncrement;
        logic       pcLoad;
        logic       pcVector;
        logic       regWrite;
        logic [1:0] resultSelect;
        logic       flagsWrite;
        logic       unitStart;
        logic       exceptionEnter;
    } datapathControl;

endpackage
